// ==== Bender.yml ====
package:
  name: fetch_subsystem

sources:
  - include_dirs:
      - logic
    files:
      - logic/fetch_pkg.sv
      - logic/fetch_buffer_store.sv
      - logic/fetch_buffer_ctrl.sv
      - logic/fetch_buffer.sv
      - logic/instr_ram.sv
      - logic/fetch_subsystem_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/fetch_tb.sv

// ==== filelist.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_buffer_store.sv
logic/fetch_buffer_ctrl.sv
logic/fetch_buffer.sv
logic/instr_ram.sv
logic/fetch_subsystem_top.sv
tb/fetch_tb.sv

// ==== logic/fetch_buffer.sv ====
`timescale 1ns/1ns

module fetch_buffer
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fetch_req_t fetch_req,
  output fetch_rsp_t fetch_rsp,
  output fetch_req_t imem_req,
  input  fetch_rsp_t imem_rsp
);

  fbuf_wr_t    wr;
  fbuf_rd_t    rd;
  fbuf_rdata_t rdata;

  fetch_buffer_store u_store (
    .clk   (clk),
    .wr    (wr),
    .rd    (rd),
    .rdata (rdata)
  );

  fetch_buffer_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .imem_rsp  (imem_rsp),
    .imem_req  (imem_req),
    .wr        (wr),
    .rd        (rd),
    .rdata     (rdata)
  );

endmodule

// ==== logic/fetch_buffer_ctrl.sv ====
`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_buffer_ctrl
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fetch_req_t  fetch_req,
  output fetch_rsp_t  fetch_rsp,
  input  fetch_rsp_t  imem_rsp,
  output fetch_req_t  imem_req,
  output fbuf_wr_t    wr,
  output fbuf_rd_t    rd,
  input  fbuf_rdata_t rdata
);

  localparam int FILL_W = `FB_IDX_W + 2;

  fbuf_state_e          state_q;
  logic [`FB_IDX_W-1:0] flush_idx_q;
  logic [FILL_W-1:0]    fill_q;
  logic [31:0]          addr_q;      // prefetch address
  priv_mode_e           mode_q;
  logic                 held_q;      // core request already seen in an earlier cycle
  logic [31:0]          req_addr_q;  // address of the word the memory is working on

  logic              first;
  logic              fence_now;
  logic              spec_now;
  logic              stuck;
  logic              advance;
  logic [31:0]       next_addr;
  logic              hit_w1;
  logic              hit_w2;
  logic              hit1;
  logic              hit2;
  logic [31:0]       word1;
  logic [31:0]       word2;
  logic [15:0]       lo_half;
  logic              comp;
  logic [FILL_W-1:0] step;
  logic [FILL_W-1:0] fill_sum;
  logic [FILL_W-1:0] fill_next;

  assign first     = fetch_req.valid && !held_q;
  assign fence_now = (state_q == FB_RUN) && first && fetch_req.fence;
  assign spec_now  = (state_q == FB_RUN) && first && fetch_req.spec;

  assign next_addr = fetch_req.addr + 32'd4;
  assign rd.raddr1 = fetch_req.addr[`FB_IDX_W+1:2];
  assign rd.raddr2 = next_addr[`FB_IDX_W+1:2];

  // a memory answer only counts as fill when it belongs to the current prefetch stream
  assign advance = (state_q == FB_RUN) && !fence_now && imem_rsp.ready &&
                   (req_addr_q == addr_q);

  always_comb begin
    wr = '0;
    if (state_q == FB_FLUSH || fence_now) begin
      wr.wen   = 1'b1;  // invalid entry, flush index is 0 when the fence is seen
      wr.waddr = flush_idx_q;
    end else if (imem_rsp.ready) begin
      wr.wen         = 1'b1;
      wr.waddr       = req_addr_q[`FB_IDX_W+1:2];
      wr.wdata.valid = 1'b1;
      wr.wdata.tag   = req_addr_q[31:2];
      wr.wdata.data  = imem_rsp.rdata;
    end
  end

  // the word being written this cycle counts as a hit too
  assign hit_w1 = wr.wen && wr.wdata.valid && (wr.wdata.tag == fetch_req.addr[31:2]);
  assign hit_w2 = wr.wen && wr.wdata.valid && (wr.wdata.tag == next_addr[31:2]);
  assign hit1   = hit_w1 || (rdata.rdata1.valid && rdata.rdata1.tag == fetch_req.addr[31:2]);
  assign hit2   = hit_w2 || (rdata.rdata2.valid && rdata.rdata2.tag == next_addr[31:2]);
  assign word1  = hit_w1 ? wr.wdata.data : rdata.rdata1.data;
  assign word2  = hit_w2 ? wr.wdata.data : rdata.rdata2.data;

  assign lo_half = fetch_req.addr[1] ? word1[31:16] : word1[15:0];
  assign comp    = (lo_half[1:0] != 2'b11);
  assign step    = comp ? FILL_W'(1) : FILL_W'(2);

  always_comb begin
    fetch_rsp = '0;
    if (state_q == FB_RUN && fetch_req.valid && !fetch_req.fence) begin
      if (!fetch_req.addr[1]) begin
        fetch_rsp.ready = hit1;
        fetch_rsp.rdata = word1;
      end else if (hit1) begin
        if (comp) begin
          fetch_rsp.ready = 1'b1;  // compressed, upper half alone
          fetch_rsp.rdata = {16'h0000, word1[31:16]};
        end else begin
          fetch_rsp.ready = hit2;
          fetch_rsp.rdata = {word2[15:0], word1[31:16]};
        end
      end
    end
  end

  // lookahead full and nothing in flight, yet the request misses, so restart at its word
  assign stuck = (state_q == FB_RUN) && fetch_req.valid && !fetch_req.fence &&
                 !fetch_rsp.ready && !imem_rsp.ready && (fill_q >= FILL_W'(`FB_MAX_FILL));

  always_comb begin
    fill_sum  = advance ? fill_q + FILL_W'(2) : fill_q;
    fill_next = fill_sum;
    if (fetch_rsp.ready && step <= fill_sum) begin
      fill_next = fill_sum - step;
    end
  end

  always_comb begin
    imem_req       = '0;
    imem_req.valid = (state_q == FB_RUN) && (fill_q < FILL_W'(`FB_MAX_FILL));
    imem_req.mode  = mode_q;
    imem_req.addr  = addr_q;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q     <= FB_RUN;
      flush_idx_q <= '0;
      fill_q      <= '0;
      addr_q      <= '0;
      mode_q      <= PRIV_MACH;
      held_q      <= 1'b0;
    end else begin
      held_q <= fetch_req.valid && !fetch_rsp.ready;
      case (state_q)
        FB_RUN: begin
          if (fence_now) begin
            state_q     <= FB_FLUSH;
            flush_idx_q <= flush_idx_q + 1'b1;
          end
          if (spec_now || stuck) begin
            addr_q <= {fetch_req.addr[31:2], 2'b00};
            fill_q <= '0;
          end else begin
            if (advance) begin
              addr_q <= addr_q + 32'd4;
            end
            fill_q <= fill_next;
          end
          if (spec_now) begin
            mode_q <= fetch_req.mode;
          end
        end
        FB_FLUSH: begin
          flush_idx_q <= flush_idx_q + 1'b1;  // wraps to 0 after the last entry
          if (&flush_idx_q) begin
            state_q <= FB_RUN;
          end
        end
        default: state_q <= FB_RUN;
      endcase
    end
  end

  // follows the memory's own accept condition
  always_ff @(posedge clk) begin
    if (imem_req.valid && !imem_rsp.ready) begin
      req_addr_q <= addr_q;
    end
  end

endmodule

// ==== logic/fetch_buffer_store.sv ====
`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_buffer_store
  import fetch_pkg::*;
(
  input  logic        clk,
  input  fbuf_wr_t    wr,
  input  fbuf_rd_t    rd,
  output fbuf_rdata_t rdata
);

  fbuf_entry_t entries [0:`FB_ENTRIES-1] = '{default: '0};  // all invalid at start

  // both read ports see the array before this cycle's write
  assign rdata.rdata1 = entries[rd.raddr1];
  assign rdata.rdata2 = entries[rd.raddr2];

  always_ff @(posedge clk) begin
    if (wr.wen) begin
      entries[wr.waddr] <= wr.wdata;
    end
  end

endmodule

// ==== logic/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// buffer index width, 3 gives 8 entries
`define FB_IDX_W 3

`define FB_ENTRIES (1 << `FB_IDX_W)

// fill limit in halfwords, leaves room for the word in flight and the word under the core
`define FB_MAX_FILL (2 * `FB_ENTRIES - 4)

// instruction memory size in 32-bit words
`define IMEM_WORDS 256

`endif

// ==== logic/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

  typedef enum logic [1:0] {
    PRIV_USER  = 2'b00,
    PRIV_SUPER = 2'b01,
    PRIV_MACH  = 2'b11
  } priv_mode_e;

  typedef enum logic {
    FB_RUN   = 1'b0,
    FB_FLUSH = 1'b1
  } fbuf_state_e;

  typedef struct packed {
    logic        valid;
    logic        fence;
    logic        spec;
    priv_mode_e  mode;
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } fetch_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [29:0] tag;   // word address of the stored word
    logic [31:0] data;
  } fbuf_entry_t;

  typedef struct packed {
    logic                 wen;
    logic [`FB_IDX_W-1:0] waddr;
    fbuf_entry_t          wdata;
  } fbuf_wr_t;

  typedef struct packed {
    logic [`FB_IDX_W-1:0] raddr1;
    logic [`FB_IDX_W-1:0] raddr2;
  } fbuf_rd_t;

  typedef struct packed {
    fbuf_entry_t rdata1;
    fbuf_entry_t rdata2;
  } fbuf_rdata_t;

endpackage

// ==== logic/fetch_subsystem_top.sv ====
`timescale 1ns/1ns

module fetch_subsystem_top
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fetch_req_t  fetch_req,
  output fetch_rsp_t  fetch_rsp,
  input  logic        prog_we,
  input  logic [7:0]  prog_addr,
  input  logic [31:0] prog_data
);

  fetch_req_t imem_req;
  fetch_rsp_t imem_rsp;

  fetch_buffer u_fetch_buffer (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .imem_req  (imem_req),
    .imem_rsp  (imem_rsp)
  );

  instr_ram u_instr_ram (
    .clk       (clk),
    .rst       (rst),
    .req       (imem_req),
    .rsp       (imem_rsp),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data)
  );

endmodule

// ==== logic/instr_ram.sv ====
`timescale 1ns/1ns
`include "fetch_macros.svh"

module instr_ram
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fetch_req_t  req,
  output fetch_rsp_t  rsp,
  input  logic        prog_we,
  input  logic [7:0]  prog_addr,
  input  logic [31:0] prog_data
);

  localparam int AW = $clog2(`IMEM_WORDS);

  logic [31:0] mem [0:`IMEM_WORDS-1];
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        accept;

  // no new request is taken in the cycle an answer goes out
  assign accept = req.valid && !ready_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= mem[req.addr[AW+1:2]];
    end
  end

  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

endmodule

// ==== tb/fetch_input.txt ====
// preload: word count, then one line per word with word index and data
// records: record count, then kind (0 plain, 1 spec, 2 fence, 3 patch), byte address, data
0000000F
00000000 00100093
00000001 00200113
00000002 00300193
00000003 02934505
00000004 45850050
00000005 05000413
00000006 06000413
00000007 07000413
00000008 08000413
00000009 09000413
0000000A 0A000413
0000000B 0B000413
00000040 40000513
00000041 41000513
00000042 42000513
00000013
00000000 00000000 00100093
00000000 00000004 00200113
00000000 00000008 00300193
00000000 0000000C 02934505
00000000 0000000E 00500293
00000000 00000012 00004585
00000000 00000014 05000413
00000000 00000018 06000413
00000000 0000001C 07000413
00000000 00000020 08000413
00000000 00000024 09000413
00000000 00000028 0A000413
00000000 0000002C 0B000413
00000001 00000100 40000513
00000000 00000104 41000513
00000000 00000108 42000513
00000003 00000108 0A5A0013
00000002 00000000 00000000
00000001 00000108 0A5A0013

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_tb
  import fetch_pkg::*;
();

  localparam int VEC_WORDS         = 256;
  localparam int CYCLES_PER_RECORD = 40;

  // record kinds in the vector file
  localparam logic [31:0] KIND_PLAIN = 32'd0;
  localparam logic [31:0] KIND_SPEC  = 32'd1;
  localparam logic [31:0] KIND_FENCE = 32'd2;
  localparam logic [31:0] KIND_PATCH = 32'd3;

  logic        clk = 1'b0;
  logic        rst;
  fetch_req_t  fetch_req;
  fetch_rsp_t  fetch_rsp;
  logic        prog_we;
  logic [7:0]  prog_addr;
  logic [31:0] prog_data;

  logic [31:0] vec [0:VEC_WORDS-1];
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          budget   = 0;    // watchdog limit in cycles, set once the vectors are read
  int          cur_rec  = -1;
  logic [31:0] cur_addr = '0;

  fetch_subsystem_top uut (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data)
  );

  always #50 clk = ~clk;

  function automatic string kind_name(input logic [31:0] kind);
    case (kind)
      KIND_PLAIN: return "plain";
      KIND_SPEC:  return "spec";
      KIND_FENCE: return "fence";
      KIND_PATCH: return "patch";
      default:    return "unknown";
    endcase
  endfunction

  // 32-bit opcode pattern that differs for every word address
  function automatic logic [31:0] fill_word(input int idx);
    return {8'(idx), ~8'(idx), 16'h0013};
  endfunction

  task automatic write_word(input logic [7:0] waddr, input logic [31:0] wdata);
    @(posedge clk);
    prog_we   <= 1'b1;
    prog_addr <= waddr;
    prog_data <= wdata;
  endtask

  task automatic load_memory(input int pre_cnt);
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      write_word(8'(i), fill_word(i));
    end
    for (int i = 0; i < pre_cnt; i++) begin
      write_word(vec[1 + 2 * i][7:0], vec[2 + 2 * i]);
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b1;
  endtask

  task automatic check_idle_ready();
    logic bad;
    bad = 1'b0;
    repeat (3) begin
      @(negedge clk);
      if (fetch_rsp.ready !== 1'b0) begin
        $display("CHECK FAILED at %0t ns: ready is %b with no request after reset",
                 $time, fetch_rsp.ready);
        bad = 1'b1;
      end
    end
    if (bad) begin
      fail_cnt++;
      $display("idle ready after reset: mismatch");
    end else begin
      pass_cnt++;
      $display("idle ready after reset: ok");
    end
  endtask

  task automatic idle_cycles();
    int unsigned n;
    n = $urandom % 4;
    repeat (n) @(posedge clk);
  endtask

  // holds the request until ready, sampled at the falling edge
  task automatic fetch_insn(input logic spec, input logic [31:0] addr,
                            output logic [31:0] data);
    @(posedge clk);
    fetch_req.valid <= 1'b1;
    fetch_req.fence <= 1'b0;
    fetch_req.spec  <= spec;
    fetch_req.mode  <= PRIV_MACH;
    fetch_req.addr  <= addr;
    do begin
      @(negedge clk);
    end while (fetch_rsp.ready !== 1'b1);
    data = fetch_rsp.rdata;
    @(posedge clk);
    fetch_req.valid <= 1'b0;
    fetch_req.spec  <= 1'b0;
  endtask

  task automatic issue_fence(input logic [31:0] addr);
    @(posedge clk);
    fetch_req.valid <= 1'b1;
    fetch_req.fence <= 1'b1;
    fetch_req.spec  <= 1'b0;
    fetch_req.addr  <= addr;
    @(posedge clk);
    fetch_req.valid <= 1'b0;
    fetch_req.fence <= 1'b0;
    repeat (`FB_ENTRIES) @(posedge clk);  // flush clears one entry per cycle
  endtask

  initial begin : main
    int          pre_cnt;
    int          rec_cnt;
    int          base;
    logic [31:0] kind;
    logic [31:0] addr;
    logic [31:0] exp_data;
    logic [31:0] got;

    rst       = 1'b1;
    fetch_req = '0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    void'($urandom(32'h9eee14f0));
    $readmemh("tb/fetch_input.txt", vec);
    if ($isunknown(vec[0])) begin
      $display("vector file tb/fetch_input.txt could not be read");
      fail_cnt++;
    end else begin
      pre_cnt = vec[0];
      rec_cnt = vec[1 + 2 * pre_cnt];
      base    = 2 + 2 * pre_cnt;
      budget  = `IMEM_WORDS + pre_cnt + 20 + rec_cnt * CYCLES_PER_RECORD;
      load_memory(pre_cnt);
      apply_reset();
      check_idle_ready();
      for (int r = 0; r < rec_cnt; r++) begin
        kind     = vec[base + 3 * r];
        addr     = vec[base + 3 * r + 1];
        exp_data = vec[base + 3 * r + 2];
        cur_rec  = r;
        cur_addr = addr;
        idle_cycles();
        case (kind)
          KIND_PLAIN, KIND_SPEC: begin
            fetch_insn(kind == KIND_SPEC, addr, got);
            if (got !== exp_data) begin
              $display("CHECK FAILED at %0t ns: %s fetch at %h returned %h, expected %h",
                       $time, kind_name(kind), addr, got, exp_data);
              fail_cnt++;
              $display("record %0d %s %h: mismatch", r, kind_name(kind), addr);
            end else begin
              pass_cnt++;
              $display("record %0d %s %h: ok", r, kind_name(kind), addr);
            end
          end
          KIND_FENCE: begin
            issue_fence(addr);
            $display("record %0d fence: done", r);
          end
          KIND_PATCH: begin
            write_word(addr[9:2], exp_data);
            @(posedge clk);
            prog_we <= 1'b0;
            $display("record %0d patch %h: done", r, addr);
          end
          default: begin
            $display("record %0d has an unknown kind %h", r, kind);
            fail_cnt++;
          end
        endcase
      end
    end
    $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (budget > 0);
    repeat (budget) @(posedge clk);
    if (cur_rec < 0) begin
      $display("timeout: memory load and reset did not finish within %0d cycles", budget);
    end else begin
      $display("timeout: record %0d at address %h never got ready", cur_rec, cur_addr);
    end
    $display("Test failed");
    $finish;
  end

endmodule
